//--- hdl/burstCounter.sv
`timescale 1ns/10ps
`include "mem_macros.svh"

module burstCounter (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  ready,
  input  memPkg::grantT         grant,
  output logic [`BEAT_BITS-1:0] beat,
  output logic                  last
);

  // index of the final word in a block
  localparam logic [`BEAT_BITS-1:0] lastBeat = `BEAT_BITS'(`BLOCK_WORDS - 1);

  // back to zero between bursts
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      beat <= '0;
    end else if (grant == memPkg::grantNone) begin
      beat <= '0;
    end else if (ready) begin
      // wraps naturally after the last beat
      beat <= beat + 1'b1;
    end
  end

  assign last = (beat == lastBeat);

endmodule

//--- hdl/busArbiter.sv
`timescale 1ns/10ps
`include "mem_macros.svh"

module busArbiter (
  input  logic                  clk,
  input  logic                  rstN,
  input  memPkg::busReqT        instrReq,
  input  memPkg::busReqT        dataReq,
  input  logic [`BEAT_BITS-1:0] beat,
  input  logic                  last,
  input  logic                  memReady,
  output memPkg::grantT         grant,
  output memPkg::busReqT        memReq
);

  memPkg::busReqT selReq;

  // grant held for a whole burst
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      grant <= memPkg::grantNone;
    end else begin
      case (grant)
        memPkg::grantNone: begin
          // data side wins a tie
          if (dataReq.request) begin
            grant <= memPkg::grantData;
          end else if (instrReq.request) begin
            grant <= memPkg::grantInstr;
          end
        end
        default: begin
          // one idle cycle after the final beat
          if (memReady && last) begin
            grant <= memPkg::grantNone;
          end
        end
      endcase
    end
  end

  // mux of the owning master
  always_comb begin
    case (grant)
      memPkg::grantInstr: selReq = instrReq;
      memPkg::grantData:  selReq = dataReq;
      default:            selReq = '0;
    endcase
  end

  assign memReq.request  = selReq.request;
  assign memReq.write    = selReq.write;
  // block base plus current beat
  assign memReq.blockAdr = {selReq.blockAdr[29:`BEAT_BITS], beat};

endmodule

//--- hdl/dataCacheArray.sv
`timescale 1ns/10ps
`include "mem_macros.svh"

module dataCacheArray (
  input  logic                  clk,
  input  logic                  rstN,
  input  memPkg::memAdrU        adr,
  input  logic [`BEAT_BITS-1:0] beat,
  input  logic                  fillWord,
  input  logic                  writeLine,
  input  logic [31:0]           writeData,
  input  logic [31:0]           fillData,
  output logic [24:0]           victimTag,
  output logic                  hit,
  output logic                  dirty,
  output logic [31:0]           readWord,
  output logic [31:0]           beatWord
);

  localparam logic [`BEAT_BITS-1:0] lastBeat = `BEAT_BITS'(`BLOCK_WORDS - 1);

  logic [24:0] tagArr  [`DCACHE_LINES];
  logic [31:0] lineArr [`DCACHE_LINES][`BLOCK_WORDS];
  logic [`DCACHE_LINES-1:0] validArr;
  logic [`DCACHE_LINES-1:0] dirtyArr;
  logic [2:0]  idx;

  assign idx = adr.dataView.index;

  // lookup of the addressed line
  assign hit       = validArr[idx] && (tagArr[idx] == adr.dataView.tag);
  assign dirty     = validArr[idx] && dirtyArr[idx];
  assign victimTag = tagArr[idx];
  assign readWord  = lineArr[idx][adr.dataView.wordOff];
  // victim word for write-back
  assign beatWord  = lineArr[idx][beat];

  // valid and dirty flags
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validArr <= '0;
      dirtyArr <= '0;
    end else if (fillWord) begin
      dirtyArr[idx] <= 1'b0;
      if (beat == lastBeat) begin
        validArr[idx] <= 1'b1;
      end
    end else if (writeLine) begin
      dirtyArr[idx] <= 1'b1;
    end
  end

  // tag and data storage
  always_ff @(posedge clk) begin
    if (fillWord) begin
      lineArr[idx][beat] <= fillData;
      if (beat == lastBeat) begin
        tagArr[idx] <= adr.dataView.tag;
      end
    end else if (writeLine) begin
      lineArr[idx][adr.dataView.wordOff] <= writeData;
    end
  end

endmodule

//--- hdl/dataCacheCtrl.sv
`timescale 1ns/10ps
`include "mem_macros.svh"

module dataCacheCtrl (
  input  logic           clk,
  input  logic           rstN,
  input  logic           memRead,
  input  logic           memWrite,
  input  memPkg::memAdrU adr,
  input  logic           hit,
  input  logic           dirty,
  input  logic [24:0]    victimTag,
  input  logic           grant,
  input  memPkg::busRspT rsp,
  output logic           dStall,
  output logic           fillWord,
  output logic           writeLine,
  output memPkg::busReqT busReq
);

  typedef enum logic [1:0] {
    idle,
    writeBack,
    fill
  } stateT;

  stateT state;
  stateT nextState;
  logic  access;
  logic  beatDone;
  logic  burstDone;

  assign access    = memRead || memWrite;
  // granted beats only
  assign beatDone  = grant && rsp.ready;
  assign burstDone = beatDone && rsp.last;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      idle: begin
        // dirty victim goes out first
        if (access && !hit) begin
          nextState = dirty ? writeBack : fill;
        end
      end
      writeBack: begin
        if (burstDone) begin
          nextState = fill;
        end
      end
      fill: begin
        if (burstDone) begin
          nextState = idle;
        end
      end
      default: nextState = idle;
    endcase
  end

  // stall until the access hits in idle
  assign dStall = (state != idle) || (access && !hit);

  // fill beats land on the ready edge
  assign fillWord = (state == fill) && beatDone;

  // store on a hit, including the one right after a fill
  assign writeLine = (state == idle) && memWrite && hit;

  // victim block while writing back, new block while filling
  assign busReq.request  = (state != idle);
  assign busReq.write    = (state == writeBack);
  assign busReq.blockAdr = (state == writeBack) ?
                           {victimTag, adr.dataView.index, `BEAT_BITS'(0)} :
                           {adr.dataView.tag, adr.dataView.index, `BEAT_BITS'(0)};

endmodule

//--- hdl/instrCache.sv
`timescale 1ns/10ps
`include "mem_macros.svh"

module instrCache (
  input  logic           clk,
  input  logic           rstN,
  input  logic [31:0]    pc,
  output logic [31:0]    instr,
  output logic           iStall,
  input  logic           grant,
  input  memPkg::busRspT rsp,
  output memPkg::busReqT busReq
);

  memPkg::memAdrU pcAdr;

  logic [23:0] tagArr  [`ICACHE_LINES];
  logic [31:0] lineArr [`ICACHE_LINES][`BLOCK_WORDS];
  logic [`ICACHE_LINES-1:0] validArr;
  logic [3:0]  idx;
  logic        hit;
  logic        fetchOn;
  logic        beatDone;

  assign pcAdr = pc;
  assign idx   = pcAdr.instrView.index;

  // fetching starts one cycle after reset is released
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      fetchOn <= 1'b0;
    end else begin
      fetchOn <= 1'b1;
    end
  end

  assign hit      = validArr[idx] && (tagArr[idx] == pcAdr.instrView.tag);
  assign iStall   = fetchOn && !hit;
  assign beatDone = grant && rsp.ready;

  // hit path straight from the array
  assign instr = lineArr[idx][pcAdr.instrView.wordOff];

  // whole block requested on a miss, read only
  assign busReq.request  = iStall;
  assign busReq.write    = 1'b0;
  assign busReq.blockAdr = {pcAdr.instrView.tag, idx, `BEAT_BITS'(0)};

  // line becomes valid with the last beat
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validArr <= '0;
    end else if (beatDone && rsp.last) begin
      validArr[idx] <= 1'b1;
    end
  end

  // tag follows the last beat too
  always_ff @(posedge clk) begin
    if (beatDone && rsp.last) begin
      tagArr[idx] <= pcAdr.instrView.tag;
    end
  end

  // one word per granted beat
  always_ff @(posedge clk) begin
    if (beatDone) begin
      lineArr[idx][rsp.beat] <= rsp.rdata;
    end
  end

endmodule

//--- hdl/memPkg.sv
`include "mem_macros.svh"

package memPkg;

  // request from one cache toward the bus
  typedef struct packed {
    logic        request;
    logic        write;
    // word address of the block, low beat bits zero
    logic [29:0] blockAdr;
  } busReqT;

  // response shared by both caches
  typedef struct packed {
    logic                   ready;
    logic [`BEAT_BITS-1:0]  beat;
    logic                   last;
    logic [31:0]            rdata;
  } busRspT;

  // one byte address split two ways
  // instr cache has 16 lines, data cache 8
  typedef union packed {
    struct packed {
      logic [23:0] tag;
      logic [3:0]  index;
      logic [1:0]  wordOff;
      logic [1:0]  byteOff;
    } instrView;
    struct packed {
      logic [24:0] tag;
      logic [2:0]  index;
      logic [1:0]  wordOff;
      logic [1:0]  byteOff;
    } dataView;
  } memAdrU;

  // current bus owner
  typedef enum logic [1:0] {
    grantNone,
    grantInstr,
    grantData
  } grantT;

endpackage

//--- hdl/memSystem.sv
`timescale 1ns/10ps
`include "mem_macros.svh"

module memSystem (
  input  logic        clk,
  input  logic        rstN,
  // instruction side
  input  logic [31:0] pc,
  output logic [31:0] instr,
  output logic        iStall,
  // data side
  input  logic [31:0] dataAdr,
  input  logic [31:0] writeData,
  input  logic        memWrite,
  input  logic        memRead,
  output logic [31:0] readData,
  output logic        dStall
);

  memPkg::busReqT instrReq;
  memPkg::busReqT dataReq;
  memPkg::busReqT memReq;
  memPkg::busRspT rsp;
  memPkg::grantT  grant;
  memPkg::memAdrU dataAdrU;

  logic                  instrGrant;
  logic                  dataGrant;
  logic [`BEAT_BITS-1:0] beat;
  logic                  last;
  logic                  memReady;
  logic [31:0]           memRdata;
  logic [31:0]           beatWord;
  logic [24:0]           victimTag;
  logic                  hit;
  logic                  dirty;
  logic                  fillWord;
  logic                  writeLine;

  assign dataAdrU   = dataAdr;
  assign instrGrant = (grant == memPkg::grantInstr);
  assign dataGrant  = (grant == memPkg::grantData);
  // response seen by both caches
  assign rsp = '{ready: memReady, beat: beat, last: last, rdata: memRdata};

  instrCache instrCache_inst (
    .clk(clk), .rstN(rstN), .pc(pc), .instr(instr), .iStall(iStall),
    .grant(instrGrant), .rsp(rsp), .busReq(instrReq));

  dataCacheCtrl dataCacheCtrl_inst (
    .clk(clk), .rstN(rstN), .memRead(memRead), .memWrite(memWrite),
    .adr(dataAdrU), .hit(hit), .dirty(dirty), .victimTag(victimTag),
    .grant(dataGrant), .rsp(rsp), .dStall(dStall), .fillWord(fillWord),
    .writeLine(writeLine), .busReq(dataReq));

  dataCacheArray dataCacheArray_inst (
    .clk(clk), .rstN(rstN), .adr(dataAdrU), .beat(beat), .fillWord(fillWord),
    .writeLine(writeLine), .writeData(writeData), .fillData(memRdata),
    .victimTag(victimTag), .hit(hit), .dirty(dirty), .readWord(readData),
    .beatWord(beatWord));

  busArbiter busArbiter_inst (
    .clk(clk), .rstN(rstN), .instrReq(instrReq), .dataReq(dataReq), .beat(beat),
    .last(last), .memReady(memReady), .grant(grant), .memReq(memReq));

  burstCounter burstCounter_inst (
    .clk(clk), .rstN(rstN), .ready(memReady), .grant(grant), .beat(beat), .last(last));

  // write data is the victim word at the current beat
  simMemory simMemory_inst (
    .clk(clk), .rstN(rstN), .memReq(memReq), .wdata(beatWord), .rdata(memRdata),
    .memReady(memReady));

endmodule

//--- hdl/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// words in one cache block
`define BLOCK_WORDS 4

// bits needed to index a word inside a block
`define BEAT_BITS 2

// instruction cache lines, direct mapped
`define ICACHE_LINES 16

// data cache lines, direct mapped
`define DCACHE_LINES 8

// simulated memory depth in 32-bit words
`define MEM_WORDS 1024

// idle cycles before each beat is ready
`define MEM_WAIT 2

`endif

//--- hdl/simMemory.sv
`timescale 1ns/10ps
`include "mem_macros.svh"

module simMemory (
  input  logic           clk,
  input  logic           rstN,
  input  memPkg::busReqT memReq,
  input  logic [31:0]    wdata,
  output logic [31:0]    rdata,
  output logic           memReady
);

  localparam int adrBits  = $clog2(`MEM_WORDS);
  localparam int waitBits = $clog2(`MEM_WAIT + 2);

  logic [31:0]         mem [`MEM_WORDS];
  logic [adrBits-1:0]  wordIdx;
  logic [waitBits-1:0] waitCnt;

  // contents start as the inverse of the byte address
  initial begin
    for (int i = 0; i < `MEM_WORDS; i++) begin
      mem[i] = ~(32'(i) << 2);
    end
  end

  // only the low word bits decode
  assign wordIdx = memReq.blockAdr[adrBits-1:0];

  // idle cycles of the current beat
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      waitCnt <= '0;
    end else if (!memReq.request || memReady) begin
      waitCnt <= '0;
    end else begin
      waitCnt <= waitCnt + 1'b1;
    end
  end

  // one-cycle pulse once the wait is over
  assign memReady = memReq.request && (waitCnt == waitBits'(`MEM_WAIT));

  // write lands on the ready cycle
  always_ff @(posedge clk) begin
    if (memReady && memReq.write) begin
      mem[wordIdx] <= wdata;
    end
  end

  assign rdata = mem[wordIdx];

endmodule

//--- list.f
+incdir+hdl
hdl/memPkg.sv
hdl/burstCounter.sv
hdl/busArbiter.sv
hdl/simMemory.sv
hdl/instrCache.sv
hdl/dataCacheArray.sv
hdl/dataCacheCtrl.sv
hdl/memSystem.sv
verification/memSystem_assert.sv
verification/memSystemTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the memory system testbench with Verilator
set -u
cd "$(dirname "$0")"

logFile=sim.log

verilator --binary --timing --assert -f list.f --top-module memSystemTb -o memSystemSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/memSystemSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -q "Result: FAILED" "$logFile"; then
  exit 1
fi
exit 0

//--- verification/memSystemTb.sv
`timescale 1ns/10ps
`include "mem_macros.svh"

module memSystemTb;

  localparam int adrBits = $clog2(`MEM_WORDS);
  // reset 1, fetch 80, read 40, write/read 45, eviction 24, contention 20
  localparam int opCount = 210;
  // eight beats per op at worst, doubled for the other master, then margin
  localparam longint watchdogNs =
    longint'(opCount) * 8 * (`MEM_WAIT + 1) * 2 * 100 + 100 * (20 + 4 * opCount);

  logic        clk;
  logic        rstN;
  logic [31:0] pc;
  logic [31:0] instr;
  logic        iStall;
  logic [31:0] dataAdr;
  logic [31:0] writeData;
  logic        memWrite;
  logic        memRead;
  logic [31:0] readData;
  logic        dStall;

  // reference copy of memory
  logic [31:0] refMem [`MEM_WORDS];
  int checks;
  int errors;
  int testErrors;
  int testsRun;

  memSystem memSystem_inst (
    .clk(clk), .rstN(rstN), .pc(pc), .instr(instr), .iStall(iStall),
    .dataAdr(dataAdr), .writeData(writeData), .memWrite(memWrite),
    .memRead(memRead), .readData(readData), .dStall(dStall));

  always #50 clk = ~clk;

  function automatic int wordOf(input logic [31:0] adr);
    return int'(adr[adrBits+1:2]);
  endfunction

  // lower half holds code
  function automatic logic [31:0] pickInstrAdr();
    return 32'($urandom_range(0, 511)) << 2;
  endfunction

  // upper half holds data
  function automatic logic [31:0] pickDataAdr();
    return 32'h800 | (32'($urandom_range(0, 511)) << 2);
  endfunction

  task automatic checkWord(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      testErrors++;
      $display("Fail %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic endTest(input string name);
    testsRun++;
    $display("test %s finished with %0d errors", name, testErrors);
    testErrors = 0;
  endtask

  task automatic fetchCheck(input string name, input logic [31:0] adr);
    @(posedge clk);
    pc <= adr;
    // pc stays put while stalled
    do begin
      @(negedge clk);
    end while (iStall);
    // memory word is the inverse of its byte address
    checkWord(name, ~adr, instr);
  endtask

  task automatic dataAccess(input string name, input logic wr, input logic [31:0] adr,
                            input logic [31:0] wdata);
    @(posedge clk);
    dataAdr   <= adr;
    writeData <= wdata;
    memWrite  <= wr;
    memRead   <= !wr;
    do begin
      @(negedge clk);
    end while (dStall);
    // completes on the coming edge
    if (wr) begin
      refMem[wordOf(adr)] = wdata;
    end else begin
      checkWord(name, refMem[wordOf(adr)], readData);
    end
    @(posedge clk);
    memWrite <= 1'b0;
    memRead  <= 1'b0;
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    int idx;
    int off;
    int tagA;
    int tagB;
    void'($urandom(77));
    clk       = 1'b0;
    rstN      = 1'b0;
    pc        = '0;
    dataAdr   = '0;
    writeData = '0;
    memWrite  = 1'b0;
    memRead   = 1'b0;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      refMem[i] = ~(32'(i) << 2);
    end
    repeat (10) @(posedge clk);
    rstN <= 1'b1;

    // first cycle out of reset
    @(negedge clk);
    checkWord("reset iStall", 32'd0, 32'(iStall));
    checkWord("reset dStall", 32'd0, 32'(dStall));
    fetchCheck("reset fetch", 32'd0);
    endTest("reset");

    for (int i = 0; i < 20; i++) begin
      a = pickInstrAdr();
      fetchCheck("ifetch", a);
      // remaining words of that block
      for (int w = 1; w < 4; w++) begin
        fetchCheck("ifetch block", a ^ (32'(w) << 2));
      end
    end
    endTest("ifetch");

    for (int i = 0; i < 20; i++) begin
      a = pickDataAdr();
      dataAccess("dread", 1'b0, a, '0);
      dataAccess("dread cached", 1'b0, a ^ 32'h4, '0);
    end
    endTest("dread");

    for (int i = 0; i < 15; i++) begin
      a = pickDataAdr();
      d = $urandom();
      dataAccess("store", 1'b1, a, d);
      dataAccess("load stored", 1'b0, a, '0);
      dataAccess("load neighbour", 1'b0, a ^ 32'h4, '0);
    end
    endTest("writeRead");

    // same index, two tags, both dirty in turn
    for (int i = 0; i < 6; i++) begin
      idx  = int'($urandom_range(0, 7));
      off  = int'($urandom_range(0, 3));
      tagA = 16 + int'($urandom_range(0, 15));
      tagB = 16 + int'((tagA - 15 + $urandom_range(0, 14)) % 16);
      a = (32'(tagA) << 7) | (32'(idx) << 4) | (32'(off) << 2);
      b = (32'(tagB) << 7) | (32'(idx) << 4) | (32'(off) << 2);
      dataAccess("evict store a", 1'b1, a, $urandom());
      dataAccess("evict store b", 1'b1, b, $urandom());
      dataAccess("evict load a", 1'b0, a, '0);
      dataAccess("evict load b", 1'b0, b, '0);
    end
    endTest("evict");

    // both caches miss together
    for (int i = 0; i < 10; i++) begin
      a = pickInstrAdr();
      b = pickDataAdr();
      fork
        fetchCheck("contention fetch", a);
        dataAccess("contention load", 1'b0, b, '0);
      join
    end
    endTest("contention");

    $display("tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdogNs);
    $display("timeout: tests still running after %0d ns", watchdogNs);
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- verification/memSystem_assert.sv
`timescale 1ns/10ps

module memSystem_assert (
  input logic           clk,
  input logic           rstN,
  input logic           iStall,
  input logic           dStall,
  input memPkg::grantT  grant,
  input logic           last,
  input logic           memReady,
  input memPkg::busReqT memReq
);

  // quiet first cycle after reset
  stallsLowAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !iStall && !dStall)
    else $error("stall high in the first cycle after reset");

  // owner fixed until the last beat
  grantHeld: assert property (@(posedge clk) disable iff (!rstN)
    (grant != memPkg::grantNone) && !(memReady && last) |=> grant == $past(grant))
    else $error("grant changed in the middle of a burst");

  // bus idle one cycle after a burst
  grantReleased: assert property (@(posedge clk) disable iff (!rstN)
    (grant != memPkg::grantNone) && memReady && last |=> grant == memPkg::grantNone)
    else $error("grant not released after the last beat");

  // a beat only ends a granted request that was already waiting
  readyWithRequest: assert property (@(posedge clk) disable iff (!rstN)
    memReady |-> (grant != memPkg::grantNone) && $past(memReq.request))
    else $error("memory ready without an active request");

endmodule

bind memSystem memSystem_assert memSystem_assert_inst (
  .clk(clk), .rstN(rstN), .iStall(iStall), .dStall(dStall), .grant(grant),
  .last(last), .memReady(memReady), .memReq(memReq));
